// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       := idStageTb
FILELIST  := verilog.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Simulation completed successfully

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: design/branchUnit.sv
module branchUnit (
	input  isaPkg::addrT       pc_i,
	input  isaPkg::wordT       inst_i,
	input  pipePkg::uopT       uop_i,
	input  isaPkg::wordT       regaData_i,
	input  isaPkg::wordT       regbData_i,
	output pipePkg::redirectT  redirect_o
);

	isaPkg::addrT npc;
	isaPkg::addrT brTarget;
	isaPkg::addrT jTarget;

	assign npc      = pc_i + isaPkg::PcStep;
	assign brTarget = npc + {{14{inst_i[isaPkg::ImmHi]}}, inst_i[isaPkg::ImmHi:isaPkg::ImmLo],
		2'b00};
	assign jTarget  = {npc[31:28], inst_i[isaPkg::IdxHi:isaPkg::IdxLo], 2'b00};	// region jump

	always_comb
	begin
		redirect_o = '0;
		case (uop_i)
			pipePkg::UopBeq:
			begin
				redirect_o.jCe   = (regaData_i == regbData_i);
				redirect_o.jAddr = brTarget;
			end
			pipePkg::UopBne:
			begin
				redirect_o.jCe   = (regaData_i != regbData_i);
				redirect_o.jAddr = brTarget;
			end
			pipePkg::UopJ, pipePkg::UopJal:
			begin
				redirect_o.jCe   = 1'b1;
				redirect_o.jAddr = jTarget;
			end
			default: redirect_o = '0;
		endcase

		// fetch is only redirected by control-flow ops
		assert (!redirect_o.jCe || uop_i inside {pipePkg::UopBeq, pipePkg::UopBne,
			pipePkg::UopJ, pipePkg::UopJal});
	end

endmodule

// File: design/idControl.sv
module idControl (
	input  isaPkg::wordT     inst_i,
	input  isaPkg::addrT     pc_i,
	output pipePkg::decodeT  decode_o
);

	isaPkg::opcodeT  opcode;
	isaPkg::functT   funct;
	isaPkg::regAddrT rs;
	isaPkg::regAddrT rt;
	isaPkg::regAddrT rd;
	isaPkg::wordT    signExt;
	isaPkg::wordT    zeroExt;
	isaPkg::wordT    upperImm;
	isaPkg::wordT    linkAddr;

	assign opcode   = inst_i[isaPkg::OpHi:isaPkg::OpLo];
	assign funct    = inst_i[isaPkg::FnHi:isaPkg::FnLo];
	assign rs       = inst_i[isaPkg::RsHi:isaPkg::RsLo];
	assign rt       = inst_i[isaPkg::RtHi:isaPkg::RtLo];
	assign rd       = inst_i[isaPkg::RdHi:isaPkg::RdLo];
	assign signExt  = {{16{inst_i[isaPkg::ImmHi]}}, inst_i[isaPkg::ImmHi:isaPkg::ImmLo]};
	assign zeroExt  = {16'h0, inst_i[isaPkg::ImmHi:isaPkg::ImmLo]};
	assign upperImm = {inst_i[isaPkg::ImmHi:isaPkg::ImmLo], 16'h0};
	assign linkAddr = pc_i + isaPkg::PcStep;	// return address for jal

	always_comb
	begin
		decode_o = '0;	// bubble unless recognised
		case (opcode)
			isaPkg::OpReg:
			begin
				decode_o.regaRead  = 1'b1;
				decode_o.regbRead  = 1'b1;
				decode_o.regcWrite = 1'b1;
				decode_o.regaAddr  = rs;
				decode_o.regbAddr  = rt;
				decode_o.regcAddr  = rd;
				case (funct)
					isaPkg::FnAdd: decode_o.uop = pipePkg::UopAdd;
					isaPkg::FnSub: decode_o.uop = pipePkg::UopSub;
					isaPkg::FnAnd: decode_o.uop = pipePkg::UopAnd;
					isaPkg::FnOr:  decode_o.uop = pipePkg::UopOr;
					isaPkg::FnXor: decode_o.uop = pipePkg::UopXor;
					isaPkg::FnSlt: decode_o.uop = pipePkg::UopSlt;
					default:       decode_o = '0;
				endcase
			end
			isaPkg::OpAddi, isaPkg::OpOri, isaPkg::OpAndi, isaPkg::OpXori, isaPkg::OpLui,
			isaPkg::OpLw:
			begin
				decode_o.regaRead  = 1'b1;
				decode_o.regcWrite = 1'b1;
				decode_o.regaAddr  = rs;
				decode_o.regcAddr  = rt;
				decode_o.imm       = zeroExt;	// logical ops
				case (opcode)
					isaPkg::OpAddi:
					begin
						decode_o.uop = pipePkg::UopAdd;
						decode_o.imm = signExt;
					end
					isaPkg::OpOri:  decode_o.uop = pipePkg::UopOr;
					isaPkg::OpAndi: decode_o.uop = pipePkg::UopAnd;
					isaPkg::OpXori: decode_o.uop = pipePkg::UopXor;
					isaPkg::OpLui:
					begin
						decode_o.uop = pipePkg::UopLui;
						decode_o.imm = upperImm;
					end
					default:
					begin
						decode_o.uop = pipePkg::UopLw;
						decode_o.imm = signExt;
					end
				endcase
			end
			isaPkg::OpSw:
			begin
				decode_o.uop      = pipePkg::UopSw;
				decode_o.regaRead = 1'b1;
				decode_o.regbRead = 1'b1;	// store data
				decode_o.regaAddr = rs;
				decode_o.regbAddr = rt;
				decode_o.imm      = signExt;
			end
			isaPkg::OpBeq, isaPkg::OpBne:
			begin
				decode_o.uop      = (opcode == isaPkg::OpBeq) ? pipePkg::UopBeq : pipePkg::UopBne;
				decode_o.regaRead = 1'b1;
				decode_o.regbRead = 1'b1;
				decode_o.regaAddr = rs;
				decode_o.regbAddr = rt;
			end
			isaPkg::OpJ: decode_o.uop = pipePkg::UopJ;
			isaPkg::OpJal:
			begin
				decode_o.uop       = pipePkg::UopJal;
				decode_o.regcWrite = 1'b1;
				decode_o.regcAddr  = isaPkg::LinkReg;
				decode_o.imm       = linkAddr;
			end
			default: decode_o = '0;
		endcase
	end

endmodule

// File: design/idExReg.sv
module idExReg (
	input  logic             clk,
	input  logic             arstN_i,
	input  pipePkg::decodeT  decode_i,
	input  isaPkg::wordT     regaData_i,
	input  isaPkg::wordT     regbData_i,
	input  logic             stall_i,
	output pipePkg::idExT    idEx_o
);

	always_ff @(posedge clk or negedge arstN_i)
	begin
		if (!arstN_i)
			idEx_o <= '0;
		else if (stall_i)
			idEx_o <= '0;	// bubble, held inst reissues next cycle
		else
		begin
			idEx_o.uop       <= decode_i.uop;
			idEx_o.regaData  <= regaData_i;
			idEx_o.regbData  <= regbData_i;
			idEx_o.regcWrite <= decode_i.regcWrite;
			idEx_o.regcAddr  <= decode_i.regcAddr;
		end
	end

	// a stall must never let a write into ex
	stallBubble: assert property (@(posedge clk) disable iff (!arstN_i)
		stall_i |=> !idEx_o.regcWrite);

	resetBubble: assert property (@(posedge clk)
		$rose(arstN_i) |-> idEx_o.uop == pipePkg::UopNop);

endmodule

// File: design/idStage.sv
module idStage (
	input  logic               clk,
	input  logic               arstN_i,
	input  isaPkg::wordT       inst_i,
	input  isaPkg::addrT       pc_i,
	input  isaPkg::wordT       regaData_i,
	input  isaPkg::wordT       regbData_i,
	input  isaPkg::wordT       exResult_i,
	input  pipePkg::fwdT       memFwd_i,
	output isaPkg::regAddrT    regaAddr_o,
	output isaPkg::regAddrT    regbAddr_o,
	output logic               regaRead_o,
	output logic               regbRead_o,
	output logic               stall_o,
	output pipePkg::redirectT  redirect_o,
	output pipePkg::idExT      idEx_o
);

	pipePkg::decodeT decode;
	isaPkg::wordT    regaData;
	isaPkg::wordT    regbData;

	// register file read requests
	assign regaAddr_o = decode.regaAddr;
	assign regbAddr_o = decode.regbAddr;
	assign regaRead_o = decode.regaRead;
	assign regbRead_o = decode.regbRead;

	idControl u_idControl (
		.inst_i   (inst_i),
		.pc_i     (pc_i),
		.decode_o (decode)
	);

	operandSelect u_operandSelect (
		.arstN_i    (arstN_i),
		.decode_i   (decode),
		.regaData_i (regaData_i),
		.regbData_i (regbData_i),
		.exResult_i (exResult_i),
		.exHeld_i   (idEx_o),	// ex stage view
		.memFwd_i   (memFwd_i),
		.regaData_o (regaData),
		.regbData_o (regbData),
		.stall_o    (stall_o)
	);

	branchUnit u_branchUnit (
		.pc_i       (pc_i),
		.inst_i     (inst_i),
		.uop_i      (decode.uop),
		.regaData_i (regaData),
		.regbData_i (regbData),
		.redirect_o (redirect_o)
	);

	idExReg u_idExReg (
		.clk        (clk),
		.arstN_i    (arstN_i),
		.decode_i   (decode),
		.regaData_i (regaData),
		.regbData_i (regbData),
		.stall_i    (stall_o),
		.idEx_o     (idEx_o)
	);

endmodule

// File: design/isaPkg.sv
package isaPkg;

	typedef logic [31:0] wordT;
	typedef logic [31:0] addrT;
	typedef logic [4:0]  regAddrT;
	typedef logic [5:0]  opcodeT;
	typedef logic [5:0]  functT;

	// primary opcodes
	localparam opcodeT OpReg  = 6'b000000;
	localparam opcodeT OpJ    = 6'b000010;
	localparam opcodeT OpJal  = 6'b000011;
	localparam opcodeT OpBeq  = 6'b000100;
	localparam opcodeT OpBne  = 6'b000101;
	localparam opcodeT OpAddi = 6'b001000;
	localparam opcodeT OpAndi = 6'b001100;
	localparam opcodeT OpOri  = 6'b001101;
	localparam opcodeT OpXori = 6'b001110;
	localparam opcodeT OpLui  = 6'b001111;
	localparam opcodeT OpLw   = 6'b100011;
	localparam opcodeT OpSw   = 6'b101011;

	// r-type function field
	localparam functT FnAdd = 6'b100000;
	localparam functT FnSub = 6'b100010;
	localparam functT FnAnd = 6'b100100;
	localparam functT FnOr  = 6'b100101;
	localparam functT FnXor = 6'b100110;
	localparam functT FnSlt = 6'b101010;

	localparam regAddrT LinkReg = 5'd31;
	localparam addrT    PcStep  = 32'd4;

	// field positions in the instruction word
	localparam int OpHi  = 31, OpLo  = 26;
	localparam int RsHi  = 25, RsLo  = 21;
	localparam int RtHi  = 20, RtLo  = 16;
	localparam int RdHi  = 15, RdLo  = 11;
	localparam int ImmHi = 15, ImmLo = 0;
	localparam int IdxHi = 25, IdxLo = 0;
	localparam int FnHi  = 5,  FnLo  = 0;

endpackage

// File: design/operandSelect.sv
module operandSelect (
	input  logic             arstN_i,
	input  pipePkg::decodeT  decode_i,
	input  isaPkg::wordT     regaData_i,
	input  isaPkg::wordT     regbData_i,
	input  isaPkg::wordT     exResult_i,
	input  pipePkg::idExT    exHeld_i,
	input  pipePkg::fwdT     memFwd_i,
	output isaPkg::wordT     regaData_o,
	output isaPkg::wordT     regbData_o,
	output logic             stall_o
);

	logic exLoad;
	logic isMemOp;
	logic hazA;
	logic hazB;

	// ex forwarding beats mem, then address add, then regfile, then imm
	function automatic isaPkg::wordT pickOperand(
		input logic            rdEn,
		input isaPkg::regAddrT addr,
		input isaPkg::wordT    rfData,
		input logic            addrAdd
	);
		if (rdEn && exHeld_i.regcWrite && exHeld_i.regcAddr == addr)
			return exResult_i;
		else if (rdEn && memFwd_i.wr && memFwd_i.addr == addr)
			return memFwd_i.data;
		else if (addrAdd)
			return rfData + decode_i.imm;
		else if (rdEn)
			return rfData;
		else
			return decode_i.imm;
	endfunction

	assign exLoad  = (exHeld_i.uop == pipePkg::UopLw);
	assign isMemOp = decode_i.uop inside {pipePkg::UopLw, pipePkg::UopSw};

	// load in ex whose result is needed now
	assign hazA = exLoad && decode_i.regaRead && exHeld_i.regcAddr == decode_i.regaAddr;
	assign hazB = exLoad && decode_i.regbRead && exHeld_i.regcAddr == decode_i.regbAddr;

	assign stall_o = arstN_i && (hazA || hazB);

	assign regaData_o = !arstN_i ? '0 :
		hazA ? regaData_i :	// don't care, bubble follows
		pickOperand(decode_i.regaRead, decode_i.regaAddr, regaData_i, isMemOp);

	assign regbData_o = !arstN_i ? '0 :
		hazB ? regbData_i :
		pickOperand(decode_i.regbRead, decode_i.regbAddr, regbData_i, 1'b0);

endmodule

// File: design/pipePkg.sv
package pipePkg;

	typedef enum logic [3:0]
	{
		UopNop,
		UopAdd,
		UopSub,
		UopAnd,
		UopOr,
		UopXor,
		UopSlt,
		UopLui,
		UopLw,
		UopSw,
		UopBeq,
		UopBne,
		UopJ,
		UopJal
	} uopT;

	// decoder output
	typedef struct packed
	{
		uopT            uop;
		logic           regaRead;
		logic           regbRead;
		logic           regcWrite;
		isaPkg::regAddrT regaAddr;
		isaPkg::regAddrT regbAddr;
		isaPkg::regAddrT regcAddr;
		isaPkg::wordT   imm;
	} decodeT;

	typedef struct packed
	{
		logic            wr;
		isaPkg::regAddrT addr;
		isaPkg::wordT    data;
	} fwdT;

	typedef struct packed
	{
		logic         jCe;
		isaPkg::addrT jAddr;
	} redirectT;

	typedef struct packed
	{
		uopT             uop;
		isaPkg::wordT    regaData;
		isaPkg::wordT    regbData;
		logic            regcWrite;
		isaPkg::regAddrT regcAddr;
	} idExT;

endpackage

// File: verif/idStageTb.sv
module idStageTb;

	localparam int ClkPeriod    = 8;
	localparam int ResetCycles  = 2;
	// issue cycles: reset check, imm, rtype, forward, load-use, mem, control
	localparam int TestCycles   = 1 + 6 + 6 + 9 + 4 + 4 + 5;
	localparam int MarginCycles = 20;
	localparam isaPkg::addrT BasePc = 32'h0040_0000;
	localparam isaPkg::wordT Nop    = 32'h0;

	logic              clk = 1'b0;
	logic              arstN;
	isaPkg::wordT      inst;
	isaPkg::addrT      pc;
	isaPkg::wordT      regaData;
	isaPkg::wordT      regbData;
	isaPkg::wordT      exResult;
	pipePkg::fwdT      memFwd;
	isaPkg::regAddrT   regaAddr;
	isaPkg::regAddrT   regbAddr;
	logic              regaRead;
	logic              regbRead;
	logic              stall;
	pipePkg::redirectT redirect;
	pipePkg::idExT     idEx;

	isaPkg::wordT rfTable [32];
	isaPkg::wordT rngState;
	int           errorCount = 0;
	int           checkCount = 0;

	// register file model, reads are combinational
	assign regaData = rfTable[regaAddr];
	assign regbData = rfTable[regbAddr];

	always #(ClkPeriod / 2) clk = ~clk;

	idStage u_idStage (
		.clk        (clk),
		.arstN_i    (arstN),
		.inst_i     (inst),
		.pc_i       (pc),
		.regaData_i (regaData),
		.regbData_i (regbData),
		.exResult_i (exResult),
		.memFwd_i   (memFwd),
		.regaAddr_o (regaAddr),
		.regbAddr_o (regbAddr),
		.regaRead_o (regaRead),
		.regbRead_o (regbRead),
		.stall_o    (stall),
		.redirect_o (redirect),
		.idEx_o     (idEx)
	);

	function automatic isaPkg::wordT xorshift(input isaPkg::wordT x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic isaPkg::wordT sext16(input logic [15:0] v);
		return {{16{v[15]}}, v};
	endfunction

	function automatic isaPkg::wordT rType(input isaPkg::regAddrT rs, input isaPkg::regAddrT rt,
		input isaPkg::regAddrT rd, input isaPkg::functT fn);
		return {isaPkg::OpReg, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic isaPkg::wordT iType(input isaPkg::opcodeT op, input isaPkg::regAddrT rs,
		input isaPkg::regAddrT rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic isaPkg::wordT jType(input isaPkg::opcodeT op, input logic [25:0] idx);
		return {op, idx};
	endfunction

	task automatic compareWord(input string name, input logic [31:0] got, input logic [31:0] exp);
		checkCount++;
		if (got !== exp)
		begin
			errorCount++;
			$display("Error: %s got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic compareIdEx(input pipePkg::uopT uop, input isaPkg::wordT a,
		input isaPkg::wordT b, input logic wr, input isaPkg::regAddrT addr);
		compareWord("idEx_o.uop", 32'(idEx.uop), 32'(uop));
		compareWord("idEx_o.regaData", idEx.regaData, a);
		compareWord("idEx_o.regbData", idEx.regbData, b);
		compareWord("idEx_o.regcWrite", 32'(idEx.regcWrite), 32'(wr));
		compareWord("idEx_o.regcAddr", 32'(idEx.regcAddr), 32'(addr));
	endtask

	// drive on the rising edge, leave at the falling edge for checks
	task automatic issueFull(input isaPkg::wordT word, input isaPkg::addrT addr,
		input isaPkg::wordT exData, input pipePkg::fwdT mem);
		@(posedge clk);
		inst     <= word;
		pc       <= addr;
		exResult <= exData;
		memFwd   <= mem;
		@(negedge clk);
	endtask

	task automatic issue(input isaPkg::wordT word);
		issueFull(word, BasePc, '0, '0);
	endtask

	task automatic immediateForms();
		issue(iType(isaPkg::OpAddi, 5'd2, 5'd3, 16'hFFFB));
		issue(Nop);
		compareIdEx(pipePkg::UopAdd, rfTable[2], 32'hFFFF_FFFB, 1'b1, 5'd3);
		issue(iType(isaPkg::OpOri, 5'd6, 5'd4, 16'h8001));
		issue(Nop);
		compareIdEx(pipePkg::UopOr, rfTable[6], 32'h0000_8001, 1'b1, 5'd4);
		issue(iType(isaPkg::OpLui, 5'd0, 5'd9, 16'h1234));
		issue(Nop);
		compareIdEx(pipePkg::UopLui, 32'h0, 32'h1234_0000, 1'b1, 5'd9);
	endtask

	task automatic rTypeCase(input isaPkg::functT fn, input pipePkg::uopT uop,
		input isaPkg::regAddrT rs, input isaPkg::regAddrT rt, input isaPkg::regAddrT rd);
		issue(rType(rs, rt, rd, fn));
		compareWord("regaRead_o", 32'(regaRead), 32'd1);
		compareWord("regbRead_o", 32'(regbRead), 32'd1);
		compareWord("regaAddr_o", 32'(regaAddr), 32'(rs));
		compareWord("regbAddr_o", 32'(regbAddr), 32'(rt));
		issue(Nop);
		compareIdEx(uop, rfTable[rs], rfTable[rt], 1'b1, rd);
	endtask

	task automatic rTypeForms();
		rTypeCase(isaPkg::FnAdd, pipePkg::UopAdd, 5'd1, 5'd2, 5'd10);
		rTypeCase(isaPkg::FnSub, pipePkg::UopSub, 5'd14, 5'd15, 5'd16);
		rTypeCase(isaPkg::FnSlt, pipePkg::UopSlt, 5'd20, 5'd21, 5'd22);
	endtask

	task automatic forwardPriority();
		issue(rType(5'd1, 5'd2, 5'd5, isaPkg::FnAdd));
		issueFull(rType(5'd5, 5'd3, 5'd8, isaPkg::FnAdd), BasePc, 32'hCAFE_0001, '0);
		issue(Nop);
		compareIdEx(pipePkg::UopAdd, 32'hCAFE_0001, rfTable[3], 1'b1, 5'd8);
		issue(rType(5'd1, 5'd2, 5'd5, isaPkg::FnAdd));
		issueFull(rType(5'd5, 5'd3, 5'd8, isaPkg::FnAdd), BasePc, 32'h1111_0000,
			'{wr: 1'b1, addr: 5'd5, data: 32'h2222_0000});
		issue(Nop);
		compareWord("idEx_o.regaData", idEx.regaData, 32'h1111_0000);
		issue(Nop);	// nothing writing r5 in ex
		issueFull(rType(5'd5, 5'd3, 5'd8, isaPkg::FnAdd), BasePc, 32'h3333_0000,
			'{wr: 1'b1, addr: 5'd5, data: 32'h4444_0000});
		issue(Nop);
		compareWord("idEx_o.regaData", idEx.regaData, 32'h4444_0000);
	endtask

	task automatic loadUseStall();
		issue(iType(isaPkg::OpLw, 5'd1, 5'd7, 16'h0010));
		issue(rType(5'd7, 5'd2, 5'd11, isaPkg::FnAdd));
		compareWord("stall_o", 32'(stall), 32'd1);
		issue(rType(5'd7, 5'd2, 5'd11, isaPkg::FnAdd));	// fetch holds the word
		compareWord("stall_o", 32'(stall), 32'd0);
		compareIdEx(pipePkg::UopNop, 32'h0, 32'h0, 1'b0, 5'd0);
		issue(Nop);
		compareIdEx(pipePkg::UopAdd, rfTable[7], rfTable[2], 1'b1, 5'd11);
	endtask

	task automatic loadsAndStores();
		issue(iType(isaPkg::OpLw, 5'd4, 5'd12, 16'hFFF8));
		issue(Nop);
		compareIdEx(pipePkg::UopLw, rfTable[4] + sext16(16'hFFF8), sext16(16'hFFF8), 1'b1, 5'd12);
		issue(iType(isaPkg::OpSw, 5'd5, 5'd13, 16'h0020));
		issue(Nop);
		compareIdEx(pipePkg::UopSw, rfTable[5] + 32'h20, rfTable[13], 1'b0, 5'd0);
	endtask

	task automatic controlFlow();
		isaPkg::addrT brPc;
		isaPkg::addrT jPc;
		isaPkg::addrT npc;
		brPc = 32'h0040_0100;
		jPc  = 32'h9FFF_FFFC;	// pc + 4 crosses into the next region
		npc  = jPc + 32'd4;
		issueFull(iType(isaPkg::OpBeq, 5'd1, 5'd1, 16'hFFFC), brPc, '0, '0);
		compareWord("redirect_o.jCe", 32'(redirect.jCe), 32'd1);
		compareWord("redirect_o.jAddr", redirect.jAddr, brPc + 32'd4 + (sext16(16'hFFFC) << 2));
		issueFull(iType(isaPkg::OpBne, 5'd2, 5'd2, 16'h0008), brPc, '0, '0);
		compareWord("redirect_o.jCe", 32'(redirect.jCe), 32'd0);
		issueFull(jType(isaPkg::OpJ, 26'h012_3456), jPc, '0, '0);
		compareWord("redirect_o.jCe", 32'(redirect.jCe), 32'd1);
		compareWord("redirect_o.jAddr", redirect.jAddr, {npc[31:28], 26'h012_3456, 2'b00});
		issueFull(jType(isaPkg::OpJal, 26'h000_0040), jPc, '0, '0);
		compareWord("redirect_o.jCe", 32'(redirect.jCe), 32'd1);
		compareWord("redirect_o.jAddr", redirect.jAddr, {npc[31:28], 26'h000_0040, 2'b00});
		issue(Nop);
		compareIdEx(pipePkg::UopJal, npc, npc, 1'b1, 5'd31);
	endtask

	initial
	begin
		rngState   = 32'd23;
		rfTable[0] = '0;	// r0 reads as zero
		for (int i = 1; i < 32; i++)
		begin
			rngState   = xorshift(rngState);
			rfTable[i] = rngState;
		end
		arstN    <= 1'b0;
		inst     <= '0;
		pc       <= BasePc;
		exResult <= '0;
		memFwd   <= '0;
		repeat (ResetCycles) @(posedge clk);
		arstN <= 1'b1;
		@(negedge clk);
		compareIdEx(pipePkg::UopNop, 32'h0, 32'h0, 1'b0, 5'd0);
		compareWord("stall_o", 32'(stall), 32'd0);
		compareWord("redirect_o.jCe", 32'(redirect.jCe), 32'd0);
		immediateForms();
		rTypeForms();
		forwardPriority();
		loadUseStall();
		loadsAndStores();
		controlFlow();
		$display("checks %0d, errors %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

	initial
	begin
		#((ResetCycles + TestCycles + MarginCycles) * ClkPeriod);
		$display("watchdog expired, the tests did not finish in time");
		$display("Simulation failed");
		$finish;
	end

endmodule

// File: verilog.f
design/isaPkg.sv
design/pipePkg.sv
design/idControl.sv
design/operandSelect.sv
design/branchUnit.sv
design/idExReg.sv
design/idStage.sv
verif/idStageTb.sv
